// File: verilog/bht_pkg.sv
package bht_pkg;

	// table geometry
	// 16 sets of 4 ways, 64 entries in all
	localparam int NUM_SETS = 16;
	localparam int NUM_WAYS = 4;

	// byte-addressed pc, split as {tag, set}
	typedef logic [9:0] pc_t;
	typedef logic [5:0] tag_t;
	typedef logic [3:0] set_t;
	typedef logic [1:0] way_t;

	// 2-bit saturating counter, msb set means predict taken
	typedef logic [1:0] ctr_t;

	// one-hot branch type
	// bit 5 beq, 4 bne, 3 blt, 2 bge, 1 bltu, 0 bgeu
	typedef logic [5:0] btype_t;

	// correction code seen by the pc mux
	typedef logic [1:0] corr_t;

	localparam corr_t CORR_NONE = 2'd0;
	// predicted taken, resolved not taken
	localparam corr_t CORR_CNI = 2'd2;
	// predicted not taken, resolved taken
	localparam corr_t CORR_PBT = 2'd3;

	// jumps start strongly taken, branches weakly not taken
	localparam ctr_t CTR_INIT_JUMP = 2'd3;
	localparam ctr_t CTR_INIT_BRANCH = 2'd1;

	// fall-through step to the next instruction
	localparam pc_t PC_STEP = 10'd4;

	// one history entry, 19 bits
	typedef struct packed {
		logic valid;
		tag_t tag;
		pc_t target;
		ctr_t ctr;
	} bht_entry_t;

	// table write request, req is a one-cycle strobe
	typedef struct packed {
		logic req;
		set_t set;
		way_t way;
		bht_entry_t entry;
	} bht_wr_t;

	// result of a set lookup
	typedef struct packed {
		logic hit;
		way_t way;
		bht_entry_t entry;
	} bht_hit_t;

	// upper pc bits
	function automatic tag_t pc_tag(input pc_t pc);
		return pc[9:4];
	endfunction

	// low pc bits select the set
	function automatic set_t pc_set(input pc_t pc);
		return pc[3:0];
	endfunction

endpackage

// File: verilog/bht_table.sv
module bht_table (
	input  logic CLK,
	input  logic arst_n,
	input  bht_pkg::set_t if_set,
	input  bht_pkg::set_t id_set,
	input  bht_pkg::set_t exe_set,
	output bht_pkg::bht_entry_t [bht_pkg::NUM_WAYS-1:0] if_ways,
	output bht_pkg::bht_entry_t [bht_pkg::NUM_WAYS-1:0] id_ways,
	output bht_pkg::bht_entry_t [bht_pkg::NUM_WAYS-1:0] exe_ways,
	input  bht_pkg::bht_wr_t wr
);

	// valid bits per set and way
	logic [bht_pkg::NUM_SETS-1:0][bht_pkg::NUM_WAYS-1:0] valid_q;

	// entry payload, kept apart from the valid bits
	bht_pkg::tag_t tag_mem [bht_pkg::NUM_SETS][bht_pkg::NUM_WAYS];
	bht_pkg::pc_t target_mem [bht_pkg::NUM_SETS][bht_pkg::NUM_WAYS];
	bht_pkg::ctr_t ctr_mem [bht_pkg::NUM_SETS][bht_pkg::NUM_WAYS];

	// gather one stored entry
	function automatic bht_pkg::bht_entry_t rd_entry(input bht_pkg::set_t s,
			input bht_pkg::way_t w);
		bht_pkg::bht_entry_t e;
		e.valid = valid_q[s][w];
		e.tag = tag_mem[s][w];
		e.target = target_mem[s][w];
		e.ctr = ctr_mem[s][w];
		return e;
	endfunction

	// three combinational read ports, one per stage
	for (genvar w = 0; w < bht_pkg::NUM_WAYS; w++) begin : g_rd
		assign if_ways[w] = rd_entry(if_set, bht_pkg::way_t'(w));
		assign id_ways[w] = rd_entry(id_set, bht_pkg::way_t'(w));
		assign exe_ways[w] = rd_entry(exe_set, bht_pkg::way_t'(w));
	end

	// valid bits clear on reset
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (wr.req) begin
			valid_q[wr.set][wr.way] <= wr.entry.valid;
		end
	end

	// payload written at the edge, no reset
	always_ff @(posedge CLK) begin
		if (wr.req) begin
			tag_mem[wr.set][wr.way] <= wr.entry.tag;
			target_mem[wr.set][wr.way] <= wr.entry.target;
			ctr_mem[wr.set][wr.way] <= wr.entry.ctr;
		end
	end

endmodule

// File: verilog/bht_set_lookup.sv
module bht_set_lookup (
	input  bht_pkg::pc_t pc,
	input  bht_pkg::bht_entry_t [bht_pkg::NUM_WAYS-1:0] ways,
	output bht_pkg::bht_hit_t result
);

	// tag of the looked-up pc
	bht_pkg::tag_t pc_tag;

	// per-way tag match, valid ways only
	logic [bht_pkg::NUM_WAYS-1:0] match;

	assign pc_tag = bht_pkg::pc_tag(pc);

	for (genvar w = 0; w < bht_pkg::NUM_WAYS; w++) begin : g_cmp
		assign match[w] = ways[w].valid && (ways[w].tag == pc_tag);
	end

	// one-hot select of the matching way
	// no match or a multiple match gives an all-zero result
	always_comb begin
		result = '0;
		if ($onehot(match)) begin
			for (int w = 0; w < bht_pkg::NUM_WAYS; w++) begin
				if (match[w]) begin
					result.hit = 1'b1;
					result.way = bht_pkg::way_t'(w);
					result.entry = ways[w];
				end
			end
		end
	end

endmodule

// File: verilog/bht_allocator.sv
module bht_allocator (
	input  logic CLK,
	input  logic arst_n,
	input  bht_pkg::pc_t id_PC,
	input  bht_pkg::pc_t id_branchtarget,
	input  logic id_is_jump,
	input  logic id_is_btype,
	input  bht_pkg::bht_hit_t id_hit,
	output bht_pkg::bht_wr_t alloc_wr
);

	// fifo replacement pointer per set
	bht_pkg::way_t [bht_pkg::NUM_SETS-1:0] fifo_ptr_q;

	bht_pkg::set_t id_set;
	logic alloc_need;

	assign id_set = bht_pkg::pc_set(id_PC);

	// decoded jump or branch not yet in the table
	assign alloc_need = (id_is_jump || id_is_btype) && !id_hit.hit;

	// new entry goes to the oldest way of the set
	always_comb begin
		alloc_wr.req = alloc_need;
		alloc_wr.set = id_set;
		alloc_wr.way = fifo_ptr_q[id_set];
		alloc_wr.entry.valid = 1'b1;
		alloc_wr.entry.tag = bht_pkg::pc_tag(id_PC);
		alloc_wr.entry.target = id_branchtarget;
		// jumps start out predicted taken
		if (id_is_jump) begin
			alloc_wr.entry.ctr = bht_pkg::CTR_INIT_JUMP;
		end else begin
			alloc_wr.entry.ctr = bht_pkg::CTR_INIT_BRANCH;
		end
	end

	// pointer steps on every request
	// 2-bit add wraps way 3 back to way 0
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			fifo_ptr_q <= '0;
		end else if (alloc_need) begin
			fifo_ptr_q[id_set] <= fifo_ptr_q[id_set] + 2'd1;
		end
	end

endmodule

// File: verilog/bht_resolver.sv
module bht_resolver (
	input  bht_pkg::pc_t exe_PC,
	input  logic exe_z,
	input  logic exe_less,
	input  bht_pkg::btype_t exe_btype,
	input  bht_pkg::bht_hit_t exe_hit,
	output bht_pkg::bht_wr_t upd_wr,
	output bht_pkg::corr_t exe_correction,
	output logic flush,
	output bht_pkg::pc_t exe_PBT,
	output bht_pkg::pc_t exe_CNI
);

	// condition met, one bit per branch type
	bht_pkg::btype_t cond_met;

	logic taken;
	logic predicted;
	logic resolve;
	bht_pkg::ctr_t ctr_next;

	// beq, bne, blt, bge, bltu, bgeu from the top bit down
	assign cond_met = {exe_z, !exe_z, exe_less, !exe_less, exe_less, !exe_less};

	// actual outcome of the resolved branch
	assign taken = |(exe_btype & cond_met);

	// prediction made at IF from the stored counter
	assign predicted = exe_hit.entry.ctr[1];

	// only branches present in the table are trained
	assign resolve = (|exe_btype) && exe_hit.hit;

	// saturating counter step toward the outcome
	always_comb begin
		ctr_next = exe_hit.entry.ctr;
		if (taken) begin
			if (exe_hit.entry.ctr != 2'd3) begin
				ctr_next = exe_hit.entry.ctr + 2'd1;
			end
		end else begin
			if (exe_hit.entry.ctr != 2'd0) begin
				ctr_next = exe_hit.entry.ctr - 2'd1;
			end
		end
	end

	// mispredict picks which redirect the pc mux takes
	always_comb begin
		exe_correction = bht_pkg::CORR_NONE;
		if (resolve && (taken != predicted)) begin
			if (taken) begin
				exe_correction = bht_pkg::CORR_PBT;
			end else begin
				exe_correction = bht_pkg::CORR_CNI;
			end
		end
	end

	// both mispredict codes have the upper bit set
	assign flush = exe_correction[1];

	// write back the hit entry with the new counter
	always_comb begin
		upd_wr.req = resolve;
		upd_wr.set = bht_pkg::pc_set(exe_PC);
		upd_wr.way = exe_hit.way;
		upd_wr.entry = exe_hit.entry;
		upd_wr.entry.ctr = ctr_next;
	end

	// stored target, zero on a miss
	assign exe_PBT = exe_hit.entry.target;

	// fall-through after the branch
	assign exe_CNI = exe_PC + bht_pkg::PC_STEP;

endmodule

// File: verilog/bht_write_arbiter.sv
module bht_write_arbiter (
	input  logic CLK,
	input  logic arst_n,
	input  bht_pkg::bht_wr_t alloc_wr,
	input  bht_pkg::bht_wr_t upd_wr,
	output bht_pkg::bht_wr_t tbl_wr
);

	// holding slot for one deferred allocation
	logic held_vld_q;
	bht_pkg::set_t held_set_q;
	bht_pkg::way_t held_way_q;
	bht_pkg::bht_entry_t held_entry_q;

	bht_pkg::bht_wr_t held_wr;
	logic load_slot;
	logic drain_slot;

	always_comb begin
		held_wr.req = held_vld_q;
		held_wr.set = held_set_q;
		held_wr.way = held_way_q;
		held_wr.entry = held_entry_q;
	end

	// allocation must wait when the port is busy
	// busy means an update, or an older held allocation going first
	assign load_slot = alloc_wr.req && (upd_wr.req || held_vld_q);

	// slot empties when it wins the port
	assign drain_slot = held_vld_q && !upd_wr.req;

	// update first, then held, then new allocation
	always_comb begin
		if (upd_wr.req) begin
			tbl_wr = upd_wr;
		end else if (held_vld_q) begin
			tbl_wr = held_wr;
		end else begin
			tbl_wr = alloc_wr;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			held_vld_q <= 1'b0;
		end else if (load_slot) begin
			held_vld_q <= 1'b1;
		end else if (drain_slot) begin
			held_vld_q <= 1'b0;
		end
	end

	// a full slot is overwritten by a newer allocation
	always_ff @(posedge CLK) begin
		if (load_slot) begin
			held_set_q <= alloc_wr.set;
			held_way_q <= alloc_wr.way;
			held_entry_q <= alloc_wr.entry;
		end
	end

endmodule

// File: verilog/bht.sv
module bht (
	input  logic CLK,
	input  logic arst_n,
	input  bht_pkg::pc_t if_PC,
	input  bht_pkg::pc_t id_PC,
	input  bht_pkg::pc_t id_branchtarget,
	input  bht_pkg::pc_t exe_PC,
	input  logic id_is_jump,
	input  logic id_is_btype,
	input  logic exe_z,
	input  logic exe_less,
	input  bht_pkg::btype_t exe_btype,
	output logic if_prediction,
	output bht_pkg::corr_t exe_correction,
	output logic flush,
	output bht_pkg::pc_t if_PBT,
	output bht_pkg::pc_t exe_PBT,
	output bht_pkg::pc_t exe_CNI
);

	// raw ways of the addressed set, per stage
	bht_pkg::bht_entry_t [bht_pkg::NUM_WAYS-1:0] if_ways;
	bht_pkg::bht_entry_t [bht_pkg::NUM_WAYS-1:0] id_ways;
	bht_pkg::bht_entry_t [bht_pkg::NUM_WAYS-1:0] exe_ways;

	// per-stage lookup results
	bht_pkg::bht_hit_t if_hit;
	bht_pkg::bht_hit_t id_hit;
	bht_pkg::bht_hit_t exe_hit;

	// write requests into and out of the arbiter
	bht_pkg::bht_wr_t alloc_wr;
	bht_pkg::bht_wr_t upd_wr;
	bht_pkg::bht_wr_t tbl_wr;

	bht_table u_table (.CLK(CLK), .arst_n(arst_n),
		.if_set(bht_pkg::pc_set(if_PC)), .id_set(bht_pkg::pc_set(id_PC)),
		.exe_set(bht_pkg::pc_set(exe_PC)),
		.if_ways(if_ways), .id_ways(id_ways), .exe_ways(exe_ways), .wr(tbl_wr));

	bht_set_lookup u_if_lookup (.pc(if_PC), .ways(if_ways), .result(if_hit));
	bht_set_lookup u_id_lookup (.pc(id_PC), .ways(id_ways), .result(id_hit));
	bht_set_lookup u_exe_lookup (.pc(exe_PC), .ways(exe_ways), .result(exe_hit));

	bht_allocator u_alloc (.CLK(CLK), .arst_n(arst_n), .id_PC(id_PC),
		.id_branchtarget(id_branchtarget), .id_is_jump(id_is_jump),
		.id_is_btype(id_is_btype), .id_hit(id_hit), .alloc_wr(alloc_wr));

	bht_resolver u_resolve (.exe_PC(exe_PC), .exe_z(exe_z), .exe_less(exe_less),
		.exe_btype(exe_btype), .exe_hit(exe_hit), .upd_wr(upd_wr),
		.exe_correction(exe_correction), .flush(flush),
		.exe_PBT(exe_PBT), .exe_CNI(exe_CNI));

	bht_write_arbiter u_arb (.CLK(CLK), .arst_n(arst_n), .alloc_wr(alloc_wr),
		.upd_wr(upd_wr), .tbl_wr(tbl_wr));

	// IF prediction, all zero on a miss
	assign if_prediction = if_hit.entry.ctr[1];
	assign if_PBT = if_hit.entry.target;

endmodule

// File: sim/bht_tb.sv
module bht_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	// cycle budget per test, summed for the watchdog
	localparam int RUN_CYCLES = 3 + 17 + 4 + 10 + 56 + 10 + 3 + 66;
	localparam int MARGIN = 50;

	logic CLK;
	logic arst_n;
	bht_pkg::pc_t if_PC;
	bht_pkg::pc_t id_PC;
	bht_pkg::pc_t id_branchtarget;
	bht_pkg::pc_t exe_PC;
	logic id_is_jump;
	logic id_is_btype;
	logic exe_z;
	logic exe_less;
	bht_pkg::btype_t exe_btype;
	logic if_prediction;
	bht_pkg::corr_t exe_correction;
	logic flush;
	bht_pkg::pc_t if_PBT;
	bht_pkg::pc_t exe_PBT;
	bht_pkg::pc_t exe_CNI;

	int n_errors = 0;
	int n_cycles = 0;
	logic [15:0] lfsr_q;

	// reference table, fifo pointers and holding slot
	bht_pkg::bht_entry_t m_tbl [16][4];
	bht_pkg::way_t m_ptr [16];
	bht_pkg::bht_wr_t m_slot;

	// expected values from the reference
	bht_pkg::bht_hit_t if_res;
	bht_pkg::bht_hit_t id_res;
	bht_pkg::bht_hit_t exe_res;
	bht_pkg::bht_wr_t alloc_req;
	logic exp_taken;
	logic upd_now;
	logic alloc_now;
	bht_pkg::ctr_t exp_ctr;
	bht_pkg::corr_t exp_corr;
	bht_pkg::pc_t exp_cni;

	bht uut (.CLK(CLK), .arst_n(arst_n), .if_PC(if_PC), .id_PC(id_PC),
		.id_branchtarget(id_branchtarget), .exe_PC(exe_PC), .id_is_jump(id_is_jump),
		.id_is_btype(id_is_btype), .exe_z(exe_z), .exe_less(exe_less),
		.exe_btype(exe_btype), .if_prediction(if_prediction),
		.exe_correction(exe_correction), .flush(flush), .if_PBT(if_PBT),
		.exe_PBT(exe_PBT), .exe_CNI(exe_CNI));

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[14:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic logic random_bit();
		logic [15:0] v;
		v = take_bits(1);
		return v[0];
	endfunction

	// one-hot branch type, picks 6 and 7 fold back onto 0 and 1
	function automatic bht_pkg::btype_t random_btype();
		logic [2:0] pick;
		pick = 3'(take_bits(3));
		if (pick > 3'd5) begin
			pick = pick - 3'd6;
		end
		return 6'b000001 << pick;
	endfunction

	// branch outcome straight from the type table
	function automatic logic outcome(input bht_pkg::btype_t bt, input logic z, input logic less);
		case (bt)
			6'b100000: return z;
			6'b010000: return !z;
			6'b001000, 6'b000010: return less;
			6'b000100, 6'b000001: return !less;
			default: return 1'b0;
		endcase
	endfunction

	// search the reference set for a valid tag match
	function automatic bht_pkg::bht_hit_t model_lookup(input bht_pkg::pc_t pc);
		bht_pkg::bht_hit_t r;
		r = '0;
		for (int w = 0; w < 4; w++) begin
			if (m_tbl[pc[3:0]][w].valid && m_tbl[pc[3:0]][w].tag == pc[9:4]) begin
				r.hit = 1'b1;
				r.way = bht_pkg::way_t'(w);
				r.entry = m_tbl[pc[3:0]][w];
			end
		end
		return r;
	endfunction

	always_comb begin
		if_res = model_lookup(if_PC);
		id_res = model_lookup(id_PC);
		exe_res = model_lookup(exe_PC);
		exp_taken = outcome(exe_btype, exe_z, exe_less);
		upd_now = (exe_btype != '0) && exe_res.hit;
		alloc_now = (id_is_jump || id_is_btype) && !id_res.hit;
		// counter moves one step toward the outcome, clamped at 0 and 3
		exp_ctr = exe_res.entry.ctr;
		if (exp_taken && exe_res.entry.ctr != 2'd3) begin
			exp_ctr = exe_res.entry.ctr + 2'd1;
		end else if (!exp_taken && exe_res.entry.ctr != 2'd0) begin
			exp_ctr = exe_res.entry.ctr - 2'd1;
		end
		exp_corr = bht_pkg::CORR_NONE;
		if (upd_now && exp_taken && !exe_res.entry.ctr[1]) begin
			exp_corr = bht_pkg::CORR_PBT;
		end else if (upd_now && !exp_taken && exe_res.entry.ctr[1]) begin
			exp_corr = bht_pkg::CORR_CNI;
		end
		exp_cni = exe_PC + 10'd4;
		alloc_req.req = 1'b1;
		alloc_req.set = id_PC[3:0];
		alloc_req.way = m_ptr[id_PC[3:0]];
		alloc_req.entry.valid = 1'b1;
		alloc_req.entry.tag = id_PC[9:4];
		alloc_req.entry.target = id_branchtarget;
		alloc_req.entry.ctr = id_is_jump ? bht_pkg::CTR_INIT_JUMP : bht_pkg::CTR_INIT_BRANCH;
	end

	// reference update at the edge: update, then held, then new allocation
	always @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s < 16; s++) begin
				m_ptr[s] <= '0;
				for (int w = 0; w < 4; w++) begin
					m_tbl[s][w] <= '0;
				end
			end
			m_slot <= '0;
		end else begin
			if (upd_now) begin
				m_tbl[exe_PC[3:0]][exe_res.way].ctr <= exp_ctr;
			end else if (m_slot.req) begin
				m_tbl[m_slot.set][m_slot.way] <= m_slot.entry;
			end else if (alloc_now) begin
				m_tbl[alloc_req.set][alloc_req.way] <= alloc_req.entry;
			end
			// a full slot just gets overwritten
			if (alloc_now && (upd_now || m_slot.req)) begin
				m_slot <= alloc_req;
			end else if (m_slot.req && !upd_now) begin
				m_slot.req <= 1'b0;
			end
			if (alloc_now) begin
				m_ptr[id_PC[3:0]] <= m_ptr[id_PC[3:0]] + 2'd1;
			end
		end
	end

	always @(posedge CLK) begin
		if (arst_n) begin
			n_cycles++;
		end
	end

	a_if_pred: assert property (@(posedge CLK) disable iff (!arst_n)
			if_prediction == if_res.entry.ctr[1])
		else begin
			n_errors++;
			$display("Fail %0t: if_prediction %b, expected %b", $time,
				$sampled(if_prediction), $sampled(if_res.entry.ctr[1]));
		end

	a_if_pbt: assert property (@(posedge CLK) disable iff (!arst_n)
			if_PBT == if_res.entry.target)
		else begin
			n_errors++;
			$display("Fail %0t: if_PBT %h, expected %h", $time,
				$sampled(if_PBT), $sampled(if_res.entry.target));
		end

	a_corr: assert property (@(posedge CLK) disable iff (!arst_n) exe_correction == exp_corr)
		else begin
			n_errors++;
			$display("Fail %0t: exe_correction %0d, expected %0d", $time,
				$sampled(exe_correction), $sampled(exp_corr));
		end

	// flush only on the two mispredict codes
	a_flush: assert property (@(posedge CLK) disable iff (!arst_n) flush == exp_corr[1])
		else begin
			n_errors++;
			$display("Fail %0t: flush %b, expected %b", $time,
				$sampled(flush), $sampled(exp_corr[1]));
		end

	a_exe_pbt: assert property (@(posedge CLK) disable iff (!arst_n)
			exe_PBT == exe_res.entry.target)
		else begin
			n_errors++;
			$display("Fail %0t: exe_PBT %h, expected %h", $time,
				$sampled(exe_PBT), $sampled(exe_res.entry.target));
		end

	a_exe_cni: assert property (@(posedge CLK) disable iff (!arst_n) exe_CNI == exp_cni)
		else begin
			n_errors++;
			$display("Fail %0t: exe_CNI %h, expected %h", $time,
				$sampled(exe_CNI), $sampled(exp_cni));
		end

	// next edge, strobes back to idle
	task automatic next_cycle();
		@(posedge CLK);
		id_is_jump <= 1'b0;
		id_is_btype <= 1'b0;
		exe_btype <= '0;
	endtask

	task automatic decode_branch(input bht_pkg::pc_t pc, input bht_pkg::pc_t tgt,
			input logic jump);
		id_PC <= pc;
		id_branchtarget <= tgt;
		id_is_jump <= jump;
		id_is_btype <= !jump;
	endtask

	task automatic execute_branch(input bht_pkg::pc_t pc, input bht_pkg::btype_t bt,
			input logic z, input logic less);
		exe_PC <= pc;
		exe_btype <= bt;
		exe_z <= z;
		exe_less <= less;
	endtask

	task automatic fetch_at(input bht_pkg::pc_t pc);
		if_PC <= pc;
	endtask

	// random pc in a given set
	function automatic bht_pkg::pc_t pc_in_set(input int s);
		return {bht_pkg::tag_t'(take_bits(6)), bht_pkg::set_t'(s)};
	endfunction

	initial begin
		bht_pkg::pc_t pc_j;
		bht_pkg::pc_t pc_b;
		bht_pkg::pc_t pc_lost;
		bht_pkg::tag_t base;
		lfsr_q = 16'd75;
		CLK = 1'b0;
		arst_n = 1'b0;
		if_PC = '0;
		id_PC = '0;
		id_branchtarget = '0;
		exe_PC = '0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		exe_z = 1'b0;
		exe_less = 1'b0;
		exe_btype = '0;
		repeat (3) @(posedge CLK);
		arst_n <= 1'b1;

		// cleared table, every set misses at IF and EXE
		for (int s = 0; s < 16; s++) begin
			next_cycle();
			fetch_at(pc_in_set(s));
			execute_branch(pc_in_set(s), random_btype(), random_bit(), random_bit());
		end

		// one jump and one branch, then fetch them
		pc_j = pc_in_set(1);
		pc_b = pc_in_set(2);
		next_cycle();
		decode_branch(pc_j, bht_pkg::pc_t'(take_bits(10)), 1'b1);
		next_cycle();
		decode_branch(pc_b, bht_pkg::pc_t'(take_bits(10)), 1'b0);
		fetch_at(pc_j);
		next_cycle();
		fetch_at(pc_b);

		// five tags into set 5, the first is evicted
		base = bht_pkg::tag_t'(take_bits(6));
		for (int i = 0; i < 5; i++) begin
			next_cycle();
			decode_branch({bht_pkg::tag_t'(base + i), 4'd5}, bht_pkg::pc_t'(take_bits(10)),
				random_bit());
		end
		for (int i = 0; i < 5; i++) begin
			next_cycle();
			fetch_at({bht_pkg::tag_t'(base + i), 4'd5});
		end

		// push the branch counter to 3, then down to 0, then random outcomes
		for (int i = 0; i < 56; i++) begin
			next_cycle();
			fetch_at(pc_b);
			if (i < 4) begin
				execute_branch(pc_b, 6'b100000, 1'b1, 1'b0);
			end else if (i < 8) begin
				execute_branch(pc_b, 6'b100000, 1'b0, 1'b0);
			end else begin
				execute_branch(pc_b, random_btype(), random_bit(), random_bit());
			end
		end

		// update and allocation in one cycle, allocation lands an edge later
		next_cycle();
		execute_branch(pc_j, 6'b100000, random_bit(), 1'b0);
		decode_branch(pc_in_set(7), bht_pkg::pc_t'(take_bits(10)), 1'b0);
		fetch_at(pc_j);
		next_cycle();
		fetch_at(id_PC);
		next_cycle();
		// two deferred in a row, the older one is lost
		pc_lost = pc_in_set(8);
		execute_branch(pc_j, 6'b010000, random_bit(), 1'b0);
		decode_branch(pc_lost, bht_pkg::pc_t'(take_bits(10)), 1'b1);
		next_cycle();
		execute_branch(pc_j, 6'b100000, random_bit(), 1'b0);
		decode_branch(pc_in_set(9), bht_pkg::pc_t'(take_bits(10)), 1'b0);
		next_cycle();
		decode_branch(pc_in_set(10), bht_pkg::pc_t'(take_bits(10)), 1'b1);
		fetch_at(id_PC);
		for (int i = 0; i < 3; i++) begin
			next_cycle();
			fetch_at(id_PC);
		end
		// the dropped allocation never reached the table
		next_cycle();
		fetch_at(pc_lost);

		// resolved branch at the evicted tag of the full set 5
		next_cycle();
		execute_branch({base, 4'd5}, random_btype(), random_bit(), random_bit());
		fetch_at({base, 4'd5});
		next_cycle();
		fetch_at(exe_PC);

		// fetch every stored tag of every set
		for (int s = 0; s < 16; s++) begin
			for (int w = 0; w < 4; w++) begin
				next_cycle();
				fetch_at({m_tbl[s][w].tag, bht_pkg::set_t'(s)});
			end
		end
		next_cycle();
		next_cycle();

		$display("%0d cycles checked, %0d errors", n_cycles, n_errors);
		if (n_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(CLK_PERIOD * (RUN_CYCLES + MARGIN));
		$display("timeout: the test sequence did not finish in %0d cycles",
			RUN_CYCLES + MARGIN);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: bht.f
verilog/bht_pkg.sv
verilog/bht_table.sv
verilog/bht_set_lookup.sv
verilog/bht_allocator.sv
verilog/bht_resolver.sv
verilog/bht_write_arbiter.sv
verilog/bht.sv
sim/bht_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bht testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module bht_tb -f bht.f -o bht_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/bht_sim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0
